// File: common/xcvr_phy_defines.svh
// sizing and sequencer timing for the PHY management block
// lane count may be set from 1 to 32; wait lengths are in clk cycles
`ifndef XCVR_PHY_DEFINES_SVH
`define XCVR_PHY_DEFINES_SVH

// lanes served by one management block
`define XCVR_LANES 4

// tx plls feeding the lanes
`define XCVR_PLLS 1

// flop stages on every async status input
`define SYNC_STAGES 2

// minimum pll powerdown hold after a full restart
`define PLL_PD_CYCLES 8

// gap between seeing a lock and releasing the next reset
`define SETTLE_CYCLES 6

`endif

// File: common/xcvr_phy_pkg.sv
// shared types for the PHY management block
// widths follow the lane and pll counts in the defines header
`default_nettype none

`include "xcvr_phy_defines.svh"

package xcvr_phy_pkg;

    typedef logic [`XCVR_LANES-1:0] lane_mask_t;  // one bit per lane
    typedef logic [`XCVR_PLLS-1:0]  pll_mask_t;   // one bit per tx pll
    typedef logic [7:0]             csr_addr_t;   // word address
    typedef logic [31:0]            csr_data_t;

    // reset control and status
    localparam csr_addr_t ADDR_RESET_CONTROL         = 8'h42;  // rd: ready flags, wr: restarts
    localparam csr_addr_t ADDR_RESET_CH_BITMASK      = 8'h43;
    localparam csr_addr_t ADDR_RESET_FINE_CONTROL    = 8'h44;  // 4 override bits

    // pma controls and synchronized status
    localparam csr_addr_t ADDR_PHY_LOOPBACK_SERIAL   = 8'h61;
    localparam csr_addr_t ADDR_PMA_PLL_IS_LOCKED     = 8'h63;
    localparam csr_addr_t ADDR_PMA_RX_SET_LOCKTOREF  = 8'h64;
    localparam csr_addr_t ADDR_PMA_RX_SET_LOCKTODATA = 8'h65;
    localparam csr_addr_t ADDR_PMA_RX_IS_LOCKEDTOREF = 8'h66;
    localparam csr_addr_t ADDR_PMA_RX_IS_LOCKEDTODATA = 8'h67;
    localparam csr_addr_t ADDR_PMA_RX_SIGNALDETECT   = 8'h68;

    // tx side: pll powerdown, then wait for pll lock
    typedef enum logic [1:0] {
        TX_PLL_PD,
        TX_WAIT_LOCK,
        TX_SETTLE,
        TX_READY
    } tx_state_t;

    // rx side: analog reset until plls lock, digital reset until cdr locks
    typedef enum logic [1:0] {
        RX_WAIT_PLL,
        RX_WAIT_DATA,
        RX_SETTLE,
        RX_READY
    } rx_state_t;

endpackage

`default_nettype wire

// File: src/status_sync.sv
// brings the async pma status buses into clk, SYNC_STAGES flops deep
// outputs clear to zero on reset, so locks read low until resampled
`timescale 1ns/1ps
`default_nettype none

`include "xcvr_phy_defines.svh"

module status_sync
    import xcvr_phy_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire pll_mask_t  pll_locked,
    input  wire lane_mask_t rx_is_lockedtoref,
    input  wire lane_mask_t rx_is_lockedtodata,
    input  wire lane_mask_t rx_signaldetect,
    output pll_mask_t  sync_pll_locked,
    output lane_mask_t sync_lockedtoref,
    output lane_mask_t sync_lockedtodata,
    output lane_mask_t sync_signaldetect
);

    // all four buses share one chain, each bit is still independent
    localparam int SYNC_W = `XCVR_PLLS + 3 * `XCVR_LANES;

    logic [SYNC_W-1:0] sync_q [`SYNC_STAGES];  // [0] is the capture flop

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `SYNC_STAGES; i++)
                sync_q[i] <= '0;
        end else begin
            sync_q[0] <= {pll_locked, rx_is_lockedtoref,  // first stage may go metastable
                          rx_is_lockedtodata, rx_signaldetect};
            for (int i = 1; i < `SYNC_STAGES; i++)
                sync_q[i] <= sync_q[i-1];
        end
    end

    // last stage only, earlier ones are not safe to use
    assign {sync_pll_locked, sync_lockedtoref, sync_lockedtodata, sync_signaldetect} =
        sync_q[`SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: reset_ctrl/reset_sequencer.sv
// tx and rx reset sequencing for all lanes together
// lock inputs must already be synchronized to clk; outputs are flops
`timescale 1ns/1ps
`default_nettype none

`include "xcvr_phy_defines.svh"

module reset_sequencer
    import xcvr_phy_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        seq_restart_all,
    input  wire        seq_restart_tx,
    input  wire        seq_restart_rx,
    input  wire pll_mask_t  sync_pll_locked,
    input  wire lane_mask_t sync_lockedtodata,
    output logic       seq_pll_powerdown,
    output logic       seq_tx_digitalreset,
    output logic       seq_rx_analogreset,
    output logic       seq_rx_digitalreset,
    output logic       tx_ready,
    output logic       rx_ready
);

    // one counter width covers both wait lengths
    localparam int CNT_MAX = (`PLL_PD_CYCLES > `SETTLE_CYCLES) ? `PLL_PD_CYCLES
                                                                 : `SETTLE_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam logic [CNT_W-1:0] PD_LAST     = CNT_W'(`PLL_PD_CYCLES - 1);
    localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(`SETTLE_CYCLES - 1);

    tx_state_t        tx_state, tx_next;
    rx_state_t        rx_state, rx_next;
    logic [CNT_W-1:0] tx_cnt, rx_cnt;
    logic             tx_cnt_clr, rx_cnt_clr;
    logic             pll_lock_all, data_lock_all;

    assign pll_lock_all  = &sync_pll_locked;    // every tx pll
    assign data_lock_all = &sync_lockedtodata;  // every lane cdr

    always_comb begin
        tx_next = tx_state;
        case (tx_state)
            TX_PLL_PD:    if (tx_cnt == PD_LAST) tx_next = TX_WAIT_LOCK;
            TX_WAIT_LOCK: if (pll_lock_all) tx_next = TX_SETTLE;
            TX_SETTLE: begin
                if (!pll_lock_all)
                    tx_next = TX_WAIT_LOCK;
                else if (tx_cnt == SETTLE_LAST)
                    tx_next = TX_READY;
            end
            TX_READY:     if (!pll_lock_all) tx_next = TX_WAIT_LOCK;  // lost lock
            default:      tx_next = TX_PLL_PD;
        endcase
        // tx restart skips powerdown, only once plls run
        if (seq_restart_tx && pll_lock_all && tx_state != TX_PLL_PD)
            tx_next = TX_SETTLE;
        if (seq_restart_all)
            tx_next = TX_PLL_PD;
    end

    always_comb begin
        rx_next = rx_state;
        case (rx_state)
            RX_WAIT_PLL:  if (pll_lock_all && rx_cnt == SETTLE_LAST) rx_next = RX_WAIT_DATA;
            RX_WAIT_DATA: if (data_lock_all) rx_next = RX_SETTLE;
            RX_SETTLE: begin
                if (!data_lock_all)
                    rx_next = RX_WAIT_DATA;  // cdr dropped out, wait again
                else if (rx_cnt == SETTLE_LAST)
                    rx_next = RX_READY;
            end
            RX_READY:     rx_next = RX_READY;
            default:      rx_next = RX_WAIT_PLL;
        endcase
        if (seq_restart_rx && rx_state != RX_WAIT_PLL)
            rx_next = RX_WAIT_DATA;
        if (seq_restart_all)
            rx_next = RX_WAIT_PLL;
    end

    // restart levels hold the counters at zero
    assign tx_cnt_clr = (tx_next != tx_state) | seq_restart_all | seq_restart_tx;
    assign rx_cnt_clr = (rx_next != rx_state) | seq_restart_all | seq_restart_rx |
                        (rx_state == RX_WAIT_PLL && !pll_lock_all);  // settle after lock only

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_state            <= TX_PLL_PD;
            tx_cnt              <= '0;
            seq_pll_powerdown   <= 1'b1;
            seq_tx_digitalreset <= 1'b1;
            tx_ready            <= 1'b0;
        end else begin
            tx_state <= tx_next;
            if (tx_cnt_clr)
                tx_cnt <= '0;
            else if (tx_cnt != CNT_W'(CNT_MAX))
                tx_cnt <= tx_cnt + 1'b1;  // saturates in wait states
            seq_pll_powerdown   <= (tx_next == TX_PLL_PD);
            seq_tx_digitalreset <= (tx_next != TX_READY);
            tx_ready            <= (tx_next == TX_READY);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_state            <= RX_WAIT_PLL;
            rx_cnt              <= '0;
            seq_rx_analogreset  <= 1'b1;
            seq_rx_digitalreset <= 1'b1;
            rx_ready            <= 1'b0;
        end else begin
            rx_state <= rx_next;
            if (rx_cnt_clr)
                rx_cnt <= '0;
            else if (rx_cnt != CNT_W'(CNT_MAX))
                rx_cnt <= rx_cnt + 1'b1;
            // analog reset also pulses for the length of an rx restart
            seq_rx_analogreset  <= (rx_next == RX_WAIT_PLL) | seq_restart_rx;
            seq_rx_digitalreset <= (rx_next != RX_READY);
            rx_ready            <= (rx_next == RX_READY);
        end
    end

    a_tx_ready_out_of_reset: assert property (@(posedge clk) disable iff (reset)
        !(tx_ready && seq_tx_digitalreset));
    a_rx_ready_out_of_reset: assert property (@(posedge clk) disable iff (reset)
        !(rx_ready && seq_rx_digitalreset));
    // pcs must stay in reset while the analog side is
    a_rx_reset_order: assert property (@(posedge clk) disable iff (reset)
        seq_rx_analogreset |-> seq_rx_digitalreset);

endmodule

`default_nettype wire

// File: csr/csr_common.sv
// register map, self clearing restart commands and lane reset combine
// readdata is registered, valid the cycle after read; unmapped reads all ones
`timescale 1ns/1ps
`default_nettype none

`include "xcvr_phy_defines.svh"

module csr_common
    import xcvr_phy_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire csr_addr_t  address,
    input  wire        read,
    input  wire        write,
    input  wire csr_data_t  writedata,
    output csr_data_t  readdata,
    input  wire pll_mask_t  sync_pll_locked,
    input  wire lane_mask_t sync_lockedtoref,
    input  wire lane_mask_t sync_lockedtodata,
    input  wire lane_mask_t sync_signaldetect,
    input  wire        tx_ready,
    input  wire        rx_ready,
    input  wire        seq_pll_powerdown,
    input  wire        seq_tx_digitalreset,
    input  wire        seq_rx_analogreset,
    input  wire        seq_rx_digitalreset,
    output logic       seq_restart_all,
    output logic       seq_restart_tx,
    output logic       seq_restart_rx,
    output logic       pll_powerdown,
    output lane_mask_t tx_digitalreset,
    output lane_mask_t rx_analogreset,
    output lane_mask_t rx_digitalreset,
    output lane_mask_t phy_loopback_serial,
    output lane_mask_t rx_set_locktoref,
    output lane_mask_t rx_set_locktodata
);

    lane_mask_t ch_mask;          // lanes the resets reach
    logic [3:0] fine_ctrl;        // 0 pll pd, 1 tx dig, 2 rx ana, 3 rx dig
    logic [2:0] tx_stretch;       // restart_tx is bit 0
    logic [2:0] rx_stretch;
    logic       ctrl_wr;          // write to the reset control word
    csr_data_t  rd_mux;

    assign ctrl_wr = write && (address == ADDR_RESET_CONTROL);

    // narrow fields zero extend through the casts
    always_comb begin
        case (address)
            ADDR_RESET_CONTROL:          rd_mux = csr_data_t'({rx_ready, tx_ready});
            ADDR_RESET_CH_BITMASK:       rd_mux = csr_data_t'(ch_mask);
            ADDR_RESET_FINE_CONTROL:     rd_mux = csr_data_t'(fine_ctrl);
            ADDR_PHY_LOOPBACK_SERIAL:    rd_mux = csr_data_t'(phy_loopback_serial);
            ADDR_PMA_PLL_IS_LOCKED:      rd_mux = csr_data_t'(sync_pll_locked);
            ADDR_PMA_RX_SET_LOCKTOREF:   rd_mux = csr_data_t'(rx_set_locktoref);
            ADDR_PMA_RX_SET_LOCKTODATA:  rd_mux = csr_data_t'(rx_set_locktodata);
            ADDR_PMA_RX_IS_LOCKEDTOREF:  rd_mux = csr_data_t'(sync_lockedtoref);
            ADDR_PMA_RX_IS_LOCKEDTODATA: rd_mux = csr_data_t'(sync_lockedtodata);
            ADDR_PMA_RX_SIGNALDETECT:    rd_mux = csr_data_t'(sync_signaldetect);
            default:                     rd_mux = '1;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readdata            <= '0;
            ch_mask             <= '1;  // all lanes enabled
            fine_ctrl           <= '0;
            phy_loopback_serial <= '0;
            rx_set_locktoref    <= '0;
            rx_set_locktodata   <= '0;
        end else begin
            if (read)
                readdata <= rd_mux;  // held between reads
            if (write) begin
                case (address)
                    ADDR_RESET_CH_BITMASK:      ch_mask <= writedata[`XCVR_LANES-1:0];
                    ADDR_RESET_FINE_CONTROL:    fine_ctrl <= writedata[3:0];
                    ADDR_PHY_LOOPBACK_SERIAL:   phy_loopback_serial <= writedata[`XCVR_LANES-1:0];
                    ADDR_PMA_RX_SET_LOCKTOREF:  rx_set_locktoref <= writedata[`XCVR_LANES-1:0];
                    ADDR_PMA_RX_SET_LOCKTODATA: rx_set_locktodata <= writedata[`XCVR_LANES-1:0];
                    default: ;  // read-only or unmapped
                endcase
            end
        end
    end

    // restart commands clear themselves
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seq_restart_all <= 1'b1;  // kicks off the power-up sequence
            tx_stretch      <= '0;
            rx_stretch      <= '0;
        end else begin
            seq_restart_all <= ctrl_wr && writedata[2];  // single cycle
            // tx and rx restarts last 3 cycles
            tx_stretch <= (ctrl_wr && writedata[0]) ? 3'b111 : {1'b0, tx_stretch[2:1]};
            rx_stretch <= (ctrl_wr && writedata[1]) ? 3'b111 : {1'b0, rx_stretch[2:1]};
        end
    end

    assign seq_restart_tx = tx_stretch[0];
    assign seq_restart_rx = rx_stretch[0];

    // fine_ctrl[0] is stored only; the pll follows the sequencer alone
    assign pll_powerdown = seq_pll_powerdown;

    // sequencer drives every lane alike, override ors in, mask gates
    assign tx_digitalreset = ch_mask & {`XCVR_LANES{seq_tx_digitalreset | fine_ctrl[1]}};
    assign rx_analogreset  = ch_mask & {`XCVR_LANES{seq_rx_analogreset | fine_ctrl[2]}};
    assign rx_digitalreset = ch_mask & {`XCVR_LANES{seq_rx_digitalreset | fine_ctrl[3]}};

    // host port carries one strobe per cycle
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

endmodule

`default_nettype wire

// File: src/xcvr_phy_mgmt.sv
// PHY management top: status sync, reset sequencer and register block
// raw status inputs may be async to clk; all outputs are clk domain
`timescale 1ns/1ps
`default_nettype none

module xcvr_phy_mgmt
    import xcvr_phy_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire csr_addr_t  address,
    input  wire        read,
    input  wire        write,
    input  wire csr_data_t  writedata,
    output csr_data_t  readdata,
    input  wire pll_mask_t  pll_locked,          // async
    input  wire lane_mask_t rx_is_lockedtoref,   // async
    input  wire lane_mask_t rx_is_lockedtodata,  // async
    input  wire lane_mask_t rx_signaldetect,     // async
    output logic       pll_powerdown,
    output lane_mask_t tx_digitalreset,
    output lane_mask_t rx_analogreset,
    output lane_mask_t rx_digitalreset,
    output lane_mask_t phy_loopback_serial,
    output lane_mask_t rx_set_locktoref,
    output lane_mask_t rx_set_locktodata
);

    pll_mask_t  sync_pll_locked;
    lane_mask_t sync_lockedtoref, sync_lockedtodata, sync_signaldetect;
    logic       seq_restart_all, seq_restart_tx, seq_restart_rx;
    logic       seq_pll_powerdown, seq_tx_digitalreset;
    logic       seq_rx_analogreset, seq_rx_digitalreset;
    logic       tx_ready, rx_ready;

    // one synchronized view for both the sequencer and readback
    status_sync status_sync_inst (
        .clk, .reset,
        .pll_locked, .rx_is_lockedtoref, .rx_is_lockedtodata, .rx_signaldetect,
        .sync_pll_locked, .sync_lockedtoref, .sync_lockedtodata, .sync_signaldetect
    );

    reset_sequencer reset_sequencer_inst (
        .clk, .reset,
        .seq_restart_all, .seq_restart_tx, .seq_restart_rx,
        .sync_pll_locked, .sync_lockedtodata,
        .seq_pll_powerdown, .seq_tx_digitalreset,
        .seq_rx_analogreset, .seq_rx_digitalreset,
        .tx_ready, .rx_ready
    );

    csr_common csr_common_inst (
        .clk, .reset,
        .address, .read, .write, .writedata, .readdata,
        .sync_pll_locked, .sync_lockedtoref, .sync_lockedtodata, .sync_signaldetect,
        .tx_ready, .rx_ready,
        .seq_pll_powerdown, .seq_tx_digitalreset,
        .seq_rx_analogreset, .seq_rx_digitalreset,
        .seq_restart_all, .seq_restart_tx, .seq_restart_rx,
        .pll_powerdown,
        .tx_digitalreset, .rx_analogreset, .rx_digitalreset,
        .phy_loopback_serial, .rx_set_locktoref, .rx_set_locktodata
    );

endmodule

`default_nettype wire

// File: bench/tb_xcvr_phy_mgmt.sv
// testbench for the PHY management block, with a small transceiver stub
// stub lock delays and register values come from LCGs seeded with 68
`timescale 1ns/1ps
`default_nettype none

`include "xcvr_phy_defines.svh"

module tb_xcvr_phy_mgmt
    import xcvr_phy_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;  // about twice the worst-case sequences
    localparam int RESET_CYCLES   = 3;

    logic        clk = 1'b0;
    logic        reset;
    csr_addr_t   address;
    logic        read, write;
    csr_data_t   writedata, readdata;
    pll_mask_t   pll_locked = '0;          // stub output
    lane_mask_t  rx_is_lockedtodata = '0;  // stub output
    lane_mask_t  rx_is_lockedtoref, rx_signaldetect;
    logic        pll_powerdown;
    lane_mask_t  tx_digitalreset, rx_analogreset, rx_digitalreset;
    lane_mask_t  phy_loopback_serial, rx_set_locktoref, rx_set_locktodata;
    logic [31:0] test_seed = 32'd68;
    logic [31:0] stub_seed = 32'd68;       // separate stream for the stub
    int          pll_wait;
    int          data_wait [`XCVR_LANES];
    int          cycle_count = 0;
    int          errors = 0;
    csr_data_t   ref_image [256];          // expected read data by address

    xcvr_phy_mgmt xcvr_phy_mgmt_inst (
        .clk, .reset,
        .address, .read, .write, .writedata, .readdata,
        .pll_locked, .rx_is_lockedtoref, .rx_is_lockedtodata, .rx_signaldetect,
        .pll_powerdown, .tx_digitalreset, .rx_analogreset, .rx_digitalreset,
        .phy_loopback_serial, .rx_set_locktoref, .rx_set_locktodata
    );

    always #5 clk = ~clk;  // 10 ns

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic csr_data_t rand_word();
        test_seed = lcg_next(test_seed);
        return {test_seed[15:0], test_seed[31:16]};  // good bits into the lane range
    endfunction

    // lock comes 3 to 12 cycles after the reset falls
    function automatic int draw_delay();
        stub_seed = lcg_next(stub_seed);
        return 3 + int'(stub_seed[31:16] % 16'd10);
    endfunction

    // transceiver stub, pll follows powerdown and each cdr its analog reset
    always @(negedge clk) begin
        if (pll_powerdown) begin
            pll_locked <= '0;
            pll_wait = draw_delay();
        end else if (pll_wait != 0)
            pll_wait = pll_wait - 1;
        else
            pll_locked <= '1;
        for (int i = 0; i < `XCVR_LANES; i++) begin
            if (rx_analogreset[i]) begin
                rx_is_lockedtodata[i] <= 1'b0;
                data_wait[i] = draw_delay();
            end else if (data_wait[i] != 0)
                data_wait[i] = data_wait[i] - 1;
            else
                rx_is_lockedtodata[i] <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, tests did not finish", cycle_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // mask gates the sequencer reset or the override
    function automatic lane_mask_t expect_lane_reset(input lane_mask_t mask,
                                                     input logic override, input logic busy);
        return mask & {`XCVR_LANES{override | busy}};
    endfunction

    task automatic check_data(input csr_data_t got, input csr_data_t want, input string what);
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_lanes(input lane_mask_t got, input lane_mask_t want, input string what);
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: %s is 'b%b, expected 'b%b", $time, what, got, want);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, want);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        address   = addr;
        writedata = data;
        write     = 1'b1;
        @(negedge clk);
        write = 1'b0;
        case (addr)  // mirror writable fields
            ADDR_RESET_CH_BITMASK, ADDR_PHY_LOOPBACK_SERIAL,
            ADDR_PMA_RX_SET_LOCKTOREF, ADDR_PMA_RX_SET_LOCKTODATA:
                ref_image[addr] = csr_data_t'(lane_mask_t'(data));
            ADDR_RESET_FINE_CONTROL: ref_image[addr] = {28'd0, data[3:0]};
            default: ;
        endcase
    endtask

    task automatic read_reg(input csr_addr_t addr, output csr_data_t data);
        address = addr;
        read    = 1'b1;
        @(negedge clk);
        read = 1'b0;
        data = readdata;  // registered on the edge just passed
    endtask

    task automatic read_and_check(input csr_addr_t addr, input string what);
        csr_data_t rd;
        read_reg(addr, rd);
        check_data(rd, ref_image[addr], what);
    endtask

    // poll until want, the keep bits must not drop meanwhile
    task automatic poll_control(input csr_data_t want, input csr_data_t keep);
        csr_data_t rd;
        do begin
            read_reg(ADDR_RESET_CONTROL, rd);
            if (keep != '0)
                check_data(rd & keep, want & keep, "ready flag held during restart");
        end while (rd != want);
    endtask

    task automatic check_lane_resets(input logic tx_busy, input logic rx_busy);
        lane_mask_t mask;
        logic [3:0] fine;
        mask = lane_mask_t'(ref_image[ADDR_RESET_CH_BITMASK]);
        fine = ref_image[ADDR_RESET_FINE_CONTROL][3:0];
        check_lanes(tx_digitalreset, expect_lane_reset(mask, fine[1], tx_busy), "tx_digitalreset");
        check_lanes(rx_analogreset, expect_lane_reset(mask, fine[2], rx_busy), "rx_analogreset");
        check_lanes(rx_digitalreset, expect_lane_reset(mask, fine[3], rx_busy), "rx_digitalreset");
    endtask

    task automatic check_powered_up();
        csr_data_t rd;
        poll_control(32'h3, 32'h0);
        check_bit(pll_powerdown, 1'b0, "pll_powerdown");
        check_lane_resets(1'b0, 1'b0);
        read_reg(ADDR_PMA_PLL_IS_LOCKED, rd);
        check_data(rd, csr_data_t'(pll_locked), "pll lock status");
        read_reg(ADDR_PMA_RX_IS_LOCKEDTODATA, rd);  // rx_ready needs every lane
        check_data(rd, csr_data_t'(lane_mask_t'('1)), "lock-to-data status");
    endtask

    function automatic lane_mask_t lane_port(input csr_addr_t addr);
        case (addr)
            ADDR_PHY_LOOPBACK_SERIAL:   return phy_loopback_serial;
            ADDR_PMA_RX_SET_LOCKTOREF:  return rx_set_locktoref;
            ADDR_PMA_RX_SET_LOCKTODATA: return rx_set_locktodata;
            default:                    return '0;
        endcase
    endfunction

    initial begin
        csr_data_t rd;
        csr_addr_t rw_addrs [4];
        rw_addrs = '{ADDR_PHY_LOOPBACK_SERIAL, ADDR_PMA_RX_SET_LOCKTOREF,
                     ADDR_PMA_RX_SET_LOCKTODATA, ADDR_RESET_CH_BITMASK};
        reset = 1'b1;
        address = '0;
        read = 1'b0;
        write = 1'b0;
        writedata = '0;
        rx_is_lockedtoref = '0;
        rx_signaldetect = '0;
        for (int a = 0; a < 256; a++)
            ref_image[a] = '1;  // unmapped
        for (int a = 'h42; a <= 'h68; a++)
            if (a <= 'h44 || (a >= 'h61 && a != 'h62))
                ref_image[a] = '0;
        ref_image[ADDR_RESET_CH_BITMASK] = csr_data_t'(lane_mask_t'('1));
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        check_powered_up();

        // control registers, three passes of random values
        for (int pass = 0; pass < 3; pass++) begin
            foreach (rw_addrs[k]) begin
                write_reg(rw_addrs[k], rand_word());
                read_and_check(rw_addrs[k], "control register readback");
                if (rw_addrs[k] != ADDR_RESET_CH_BITMASK)
                    check_lanes(lane_port(rw_addrs[k]), lane_mask_t'(ref_image[rw_addrs[k]]),
                                "control output");
            end
        end
        read_and_check(8'h00, "unmapped read");
        read_and_check(8'h62, "unmapped read");
        read_and_check(8'hff, "unmapped read");

        // async status through the synchronizer
        for (int pass = 0; pass < 3; pass++) begin
            rx_signaldetect   = lane_mask_t'(rand_word());
            rx_is_lockedtoref = lane_mask_t'(rand_word());
            ref_image[ADDR_PMA_RX_SIGNALDETECT]   = csr_data_t'(rx_signaldetect);
            ref_image[ADDR_PMA_RX_IS_LOCKEDTOREF] = csr_data_t'(rx_is_lockedtoref);
            repeat (`SYNC_STAGES + 2) @(negedge clk);
            read_and_check(ADDR_PMA_RX_SIGNALDETECT, "signal detect status");
            read_and_check(ADDR_PMA_RX_IS_LOCKEDTOREF, "lock-to-ref status");
        end

        // overrides with the sequencer idle
        for (int pass = 0; pass < 3; pass++) begin
            write_reg(ADDR_RESET_FINE_CONTROL, rand_word());
            write_reg(ADDR_RESET_CH_BITMASK, rand_word());
            check_lane_resets(1'b0, 1'b0);
            read_and_check(ADDR_RESET_FINE_CONTROL, "fine control readback");
            check_bit(pll_powerdown, 1'b0, "pll_powerdown under override");
        end
        write_reg(ADDR_RESET_FINE_CONTROL, '0);
        write_reg(ADDR_RESET_CH_BITMASK, rand_word());

        write_reg(ADDR_RESET_CONTROL, 32'h1);  // tx restart
        @(negedge clk);                        // flags follow the restart level a cycle late
        read_reg(ADDR_RESET_CONTROL, rd);
        check_data(rd, 32'h2, "ready flags after tx restart");
        check_lane_resets(1'b1, 1'b0);
        poll_control(32'h3, 32'h2);

        write_reg(ADDR_RESET_CONTROL, 32'h2);  // rx restart
        @(negedge clk);
        read_reg(ADDR_RESET_CONTROL, rd);
        check_data(rd, 32'h1, "ready flags after rx restart");
        check_lane_resets(1'b0, 1'b1);
        poll_control(32'h3, 32'h1);

        write_reg(ADDR_RESET_CH_BITMASK, '1);
        write_reg(ADDR_RESET_CONTROL, 32'h4);  // full restart
        @(negedge clk);
        read_reg(ADDR_RESET_CONTROL, rd);
        check_data(rd, 32'h0, "ready flags after full restart");
        check_bit(pll_powerdown, 1'b1, "pll_powerdown after full restart");
        check_powered_up();

        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/xcvr_phy_pkg.sv
src/status_sync.sv
reset_ctrl/reset_sequencer.sv
csr/csr_common.sv
src/xcvr_phy_mgmt.sv
bench/tb_xcvr_phy_mgmt.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, and decide from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_xcvr_phy_mgmt -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
